// ==== rv_decode.f ====
rtl/rv_decode_pkg.sv
rtl/rv_decode_if.sv
rtl/rv_base_decoder.sv
rtl/rv_compressed_decoder.sv
rtl/rv_decode_stage.sv
rtl/rv_decode_top.sv
verification/rv_decode_checker.sv
verification/rv_decode_tb.sv

// ==== verification/rv_decode_tb.sv ====
// Testbench for the decode stage with clock, reset, stimulus table, checking loop and watchdog
module rv_decode_tb import rv_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_ROWS     = 29;

    typedef struct packed {
        logic [31:0] instr;
        logic        c_en;
        logic        vin;     // Also the expected valid_out
        ilen_t       ilen;
        opcode_t     opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [1:0]  funct2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        imm_t        imm;
        logic        c_flag;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        valid_in;
    logic        c_en;
    logic [31:0] instr;
    logic        valid_out;
    ilen_t       ilen;
    opcode_t     opcode;
    reg_idx_t    rd_idx;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    logic [1:0]  funct2;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    imm_t        imm;
    logic        c_flag;

    // instr, c_en, valid_in, ilen, opcode, rd, rs1, rs2, funct2, funct3, funct7, imm, c_flag
    row_t stim [NUM_ROWS] = '{
        '{32'h00000000, 1, 0, LEN_NONE, 0, 0, 0, 0, 0, 0, 0, 0, 0},     // Idle after reset
        '{32'h800012B7, 1, 1, LEN_32, 'h37, 5, 0, 0, 0, 0, 0, 'h180001, 0}, // lui t0, 0x80001
        '{32'hFFDFF0EF, 1, 1, LEN_32, 'h6F, 1, 0, 0, 0, 0, 0, 'h1FFFFC, 0}, // jal ra, -4
        '{32'hFF813503, 1, 1, LEN_32, 'h03, 10, 2, 0, 0, 3, 0, 'h1FFFF8, 0}, // ld a0, -8(sp)
        '{32'h7FF38313, 1, 1, LEN_32, 'h13, 6, 7, 0, 0, 0, 0, 'h7FF, 0},   // addi t1, t2, 2047
        '{32'h40D605BB, 1, 1, LEN_32, 'h3B, 11, 12, 13, 0, 0, 'h20, 0, 0}, // subw a1, a2, a3
        '{32'hFE6288E3, 1, 1, LEN_32, 'h63, 0, 5, 6, 0, 0, 0, 'h1FFFF0, 0}, // beq t0, t1, -16
        '{32'h00942A23, 1, 1, LEN_32, 'h23, 0, 8, 9, 0, 2, 0, 'h14, 0},    // sw s1, 20(s0)
        '{32'hABCDE00B, 1, 1, LEN_32, 0, 0, 0, 0, 0, 0, 0, 0, 0},        // Custom-0 opcode
        '{32'h00000424, 1, 1, LEN_16, 0, 9, 2, 0, 0, 0, 0, 'h208, 0},      // c.addi4spn s1, 520
        '{32'h000045E8, 1, 1, LEN_16, 0, 10, 11, 0, 0, 2, 0, 'h4C, 0},     // c.lw a0, 76(a1)
        '{32'h00007FE0, 1, 1, LEN_16, 0, 8, 15, 0, 0, 3, 0, 'hF8, 0},      // c.ld s0, 248(a5)
        '{32'h00005675, 1, 1, LEN_16, 1, 12, 0, 0, 0, 2, 0, 'h1FFFFD, 0},  // c.li a2, -3
        '{32'h00007785, 1, 1, LEN_16, 1, 15, 0, 0, 0, 3, 0, 'h1E1000, 0},  // c.lui a5, -31
        '{32'h00007139, 1, 1, LEN_16, 1, 2, 2, 0, 0, 3, 0, 'h1FFFC0, 0},   // c.addi16sp -64
        '{32'h000088BD, 1, 1, LEN_16, 1, 9, 9, 0, 2, 4, 0, 'hF, 0},        // c.andi s1, 15
        '{32'h00008C15, 1, 1, LEN_16, 1, 8, 8, 13, 0, 4, 'h46, 0, 0},      // c.sub s0, a3
        '{32'h0000A46D, 1, 1, LEN_16, 1, 0, 0, 0, 0, 5, 0, 'h2AA, 0},      // c.j 682
        '{32'h0000FD6D, 1, 1, LEN_16, 1, 0, 10, 0, 0, 7, 0, 'h1FFFFA, 0},  // c.bnez a0, -6
        '{32'h00001506, 1, 1, LEN_16, 2, 10, 10, 0, 0, 0, 0, 'h21, 0},     // c.slli a0, 33
        '{32'h0000471E, 1, 1, LEN_16, 2, 14, 2, 0, 0, 2, 0, 'hC4, 0},      // c.lwsp a4, 196
        '{32'h0000F726, 1, 1, LEN_16, 2, 0, 2, 9, 0, 7, 0, 'h1A8, 0},      // c.sdsp s1, 424
        '{32'h0000852E, 1, 1, LEN_16, 2, 10, 0, 11, 0, 4, 'h40, 0, 1},     // c.mv a0, a1
        '{32'h00008082, 1, 1, LEN_16, 2, 0, 1, 0, 0, 4, 'h40, 0, 0},       // c.jr ra
        '{32'h00009282, 1, 1, LEN_16, 2, 1, 5, 0, 0, 4, 'h48, 0, 1},       // c.jalr t0
        '{32'h0000852E, 0, 1, LEN_16, 0, 0, 0, 0, 0, 0, 0, 0, 0},        // c.mv, c_en low
        '{32'hFFF7079B, 0, 1, LEN_32, 'h1B, 15, 14, 0, 0, 0, 0, 'h1FFFFF, 0}, // addiw a5, a4, -1
        '{32'h00008082, 1, 0, LEN_32, 'h1B, 15, 14, 0, 0, 0, 0, 'h1FFFFF, 0}, // Idle, fields hold
        '{32'h00008082, 1, 1, LEN_16, 2, 0, 1, 0, 0, 4, 'h40, 0, 0}        // c.jr ra after idle
    };

    rv_decode_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .instr     (instr),
        .c_en      (c_en),
        .valid_out (valid_out),
        .ilen      (ilen),
        .opcode    (opcode),
        .rd_idx    (rd_idx),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .funct2    (funct2),
        .funct3    (funct3),
        .funct7    (funct7),
        .imm       (imm),
        .c_flag    (c_flag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic apply_row(input row_t r);
        instr    = r.instr;
        c_en     = r.c_en;
        valid_in = r.vin;
    endtask

    task automatic compare_field(input string where, input string name,
                                 input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s %s is 'h%0h, expected 'h%0h",
                     $time, where, name, got, exp);
            $display("Test failed");
            $fatal(1, "Output mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input row_t r, input string where);
        compare_field(where, "valid_out", 32'(valid_out), 32'(r.vin));
        compare_field(where, "ilen", 32'(ilen), 32'(r.ilen));
        compare_field(where, "opcode", 32'(opcode), 32'(r.opcode));
        compare_field(where, "rd_idx", 32'(rd_idx), 32'(r.rd));
        compare_field(where, "rs1_idx", 32'(rs1_idx), 32'(r.rs1));
        compare_field(where, "rs2_idx", 32'(rs2_idx), 32'(r.rs2));
        compare_field(where, "funct2", 32'(funct2), 32'(r.funct2));
        compare_field(where, "funct3", 32'(funct3), 32'(r.funct3));
        compare_field(where, "funct7", 32'(funct7), 32'(r.funct7));
        compare_field(where, "imm", 32'(imm), 32'(r.imm));
        compare_field(where, "c_flag", 32'(c_flag), 32'(r.c_flag));
    endtask

    initial begin
        rst_n    = 1'b0;
        valid_in = 1'b0;
        c_en     = 1'b0;
        instr    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_outputs(stim[0], "reset"); // Row 0 holds the cleared output set
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(stim[i]);
            @(negedge clk); // One cycle of latency
            check_outputs(stim[i], $sformatf("row %0d", i));
        end
        if (DUT.u_stage.u_checker.fail_count != 0) begin
            $display("Test failed");
            $fatal(1, "Bound assertions failed %0d times", DUT.u_stage.u_checker.fail_count);
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #((NUM_ROWS + 10) * CLK_PERIOD);
        $display("Test failed");
        $fatal(1, "Timeout, the stimulus table was not finished in time");
    end

endmodule

// ==== verification/rv_decode_checker.sv ====
// Bound assertions on valid timing, reset clearing and the compressed move/link flag
module rv_decode_checker import rv_decode_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  valid_in,
    input logic  valid_out,
    input ilen_t ilen,
    input logic  c_flag
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0; // Failed assertion count

    valid_follows: assert property (@(posedge clk) $past(rst_n) |-> valid_out == $past(valid_in))
        else begin
            $error("valid_out does not follow valid_in by one cycle");
            fail_count++;
        end

    valid_cleared: assert property (@(posedge clk) !rst_n |=> !valid_out)
        else begin
            $error("valid_out not low after a reset edge");
            fail_count++;
        end

    // Only C.MV and C.JALR raise the flag
    flag_compressed: assert property (@(posedge clk) c_flag |-> ilen == LEN_16)
        else begin
            $error("c_flag high for a word that is not 16 bits");
            fail_count++;
        end

endmodule

bind rv_decode_stage rv_decode_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .valid_out (valid_out),
    .ilen      (ilen),
    .c_flag    (c_flag)
);

// ==== rtl/rv_decode_top.sv ====
// Decode stage top level with plain ports, both decoders and the output stage
module rv_decode_top import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_in,
    input  logic [31:0] instr,
    input  logic        c_en,      // Compressed decode enable
    output logic        valid_out,
    output ilen_t       ilen,
    output opcode_t     opcode,
    output reg_idx_t    rd_idx,
    output reg_idx_t    rs1_idx,
    output reg_idx_t    rs2_idx,
    output logic [1:0]  funct2,
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output imm_t        imm,
    output logic        c_flag
);

    rv_word_u instr_w;

    rv_decode_if base_if ();
    rv_decode_if comp_if ();

    assign instr_w = rv_word_u'(instr);

    rv_base_decoder u_base (
        .instr    (instr_w),
        .decode_o (base_if.source)
    );

    rv_compressed_decoder u_comp (
        .instr    (instr_w),
        .c_en     (c_en),
        .decode_o (comp_if.source)
    );

    rv_decode_stage u_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .instr     (instr_w),
        .base      (base_if.sink),
        .comp      (comp_if.sink),
        .valid_out (valid_out),
        .ilen      (ilen),
        .opcode    (opcode),
        .rd_idx    (rd_idx),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .funct2    (funct2),
        .funct3    (funct3),
        .funct7    (funct7),
        .imm       (imm),
        .c_flag    (c_flag)
    );

endmodule

// ==== rtl/rv_decode_stage.sv ====
// Length classification, decoder selection and registered output stage with valid
module rv_decode_stage import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid_in,
    input  rv_word_u    instr,
    rv_decode_if.sink   base,
    rv_decode_if.sink   comp,
    output logic        valid_out,
    output ilen_t       ilen,
    output opcode_t     opcode,
    output reg_idx_t    rd_idx,
    output reg_idx_t    rs1_idx,
    output reg_idx_t    rs2_idx,
    output logic [1:0]  funct2,
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output imm_t        imm,
    output logic        c_flag
);

    ilen_t ilen_nxt;
    logic  pick_comp;

    // Standard length encoding from the low bits
    always_comb begin
        if (instr.b.opcode[1:0] != 2'b11) begin
            ilen_nxt = LEN_16;
        end else if (instr.b.opcode[4:2] != 3'b111) begin
            ilen_nxt = LEN_32;
        end else if (!instr.b.opcode[6]) begin
            ilen_nxt = LEN_LONG;
        end else begin
            ilen_nxt = LEN_NONE;
        end
    end

    assign pick_comp = (ilen_nxt == LEN_16);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            ilen      <= LEN_NONE;
            opcode    <= '0;
            rd_idx    <= '0;
            rs1_idx   <= '0;
            rs2_idx   <= '0;
            funct2    <= '0;
            funct3    <= '0;
            funct7    <= '0;
            imm       <= '0;
            c_flag    <= 1'b0;
        end else begin
            valid_out <= valid_in;
            if (valid_in) begin // Fields hold on idle cycles
                ilen    <= ilen_nxt;
                opcode  <= pick_comp ? comp.opcode : base.opcode;
                rd_idx  <= pick_comp ? comp.rd     : base.rd;
                rs1_idx <= pick_comp ? comp.rs1    : base.rs1;
                rs2_idx <= pick_comp ? comp.rs2    : base.rs2;
                funct2  <= pick_comp ? comp.funct2 : base.funct2;
                funct3  <= pick_comp ? comp.funct3 : base.funct3;
                funct7  <= pick_comp ? comp.funct7 : base.funct7;
                imm     <= pick_comp ? comp.imm    : base.imm;
                c_flag  <= pick_comp ? comp.c_flag : base.c_flag;
            end
        end
    end

endmodule

// ==== rtl/rv_compressed_decoder.sv ====
// Combinational expander of 16-bit compressed instructions into base-style fields
module rv_compressed_decoder import rv_decode_pkg::*; (
    input rv_word_u     instr,
    input logic         c_en,
    rv_decode_if.source decode_o
);

    comp_view_t  cv;
    logic [15:0] hw;

    // Three-bit register field selects x8..x15
    function automatic reg_idx_t creg(input logic [2:0] r);
        return {2'b01, r};
    endfunction

    assign cv = instr.c;
    assign hw = {cv.funct3, cv.b12, cv.hi5, cv.lo5, cv.quad};

    always_comb begin
        decode_o.opcode = '0;
        decode_o.rd     = '0;
        decode_o.rs1    = '0;
        decode_o.rs2    = '0;
        decode_o.funct2 = '0;
        decode_o.funct3 = '0;
        decode_o.funct7 = '0;
        decode_o.imm    = '0;
        decode_o.c_flag = 1'b0;
        if (c_en && cv.quad != 2'b11) begin
            decode_o.opcode = {5'd0, cv.quad};
            decode_o.funct3 = cv.funct3;
            case (cv.quad)
                C_Q0: begin
                    case (cv.funct3)
                        3'b000: if (hw[12:5] != '0) begin // C.ADDI4SPN
                            decode_o.rd  = creg(hw[4:2]);
                            decode_o.rs1 = SP_IDX;
                            decode_o.imm = {11'd0, hw[10:7], hw[12:11], hw[5], hw[6], 2'b00};
                        end
                        3'b010, 3'b011, 3'b110, 3'b111: begin // C.LW C.LD C.SW C.SD
                            decode_o.rs1 = creg(hw[9:7]);
                            if (cv.funct3[2]) begin
                                decode_o.rs2 = creg(hw[4:2]);
                            end else begin
                                decode_o.rd = creg(hw[4:2]);
                            end
                            if (cv.funct3[0]) begin
                                decode_o.imm = {13'd0, hw[6:5], hw[12:10], 3'b000};
                            end else begin
                                decode_o.imm = {14'd0, hw[5], hw[12:10], hw[6], 2'b00};
                            end
                        end
                        default: ; // FP forms and reserved
                    endcase
                end
                C_Q1: begin
                    case (cv.funct3)
                        3'b000, 3'b001, 3'b010: if (cv.hi5 != '0) begin // C.ADDI C.ADDIW C.LI
                            decode_o.rd  = cv.hi5;
                            decode_o.rs1 = cv.funct3[1] ? '0 : cv.hi5;
                            decode_o.imm = {{15{hw[12]}}, hw[12], hw[6:2]};
                        end
                        3'b011: if (cv.hi5 == SP_IDX) begin // C.ADDI16SP
                            decode_o.rd  = SP_IDX;
                            decode_o.rs1 = SP_IDX;
                            decode_o.imm = {{11{hw[12]}}, hw[12], hw[4:3], hw[5], hw[2],
                                            hw[6], 4'b0000};
                        end else if (cv.hi5 != '0) begin // C.LUI
                            decode_o.rd  = cv.hi5;
                            decode_o.imm = {{3{hw[12]}}, hw[12], hw[6:2], 12'd0};
                        end
                        3'b100: begin
                            decode_o.rd  = creg(hw[9:7]);
                            decode_o.rs1 = creg(hw[9:7]);
                            if (hw[11:10] != 2'b11) begin // C.SRLI C.SRAI C.ANDI
                                decode_o.funct2 = hw[11:10];
                                decode_o.imm    = {{15{hw[12]}}, hw[12], hw[6:2]};
                            end else begin // C.SUB C.XOR C.OR C.AND C.SUBW C.ADDW
                                decode_o.funct2 = hw[6:5];
                                decode_o.rs2    = creg(hw[4:2]);
                                decode_o.funct7 = {hw[15:10], 1'b0};
                            end
                        end
                        3'b101: begin // C.J
                            decode_o.imm = {{9{hw[12]}}, hw[12], hw[8], hw[10:9], hw[6], hw[7],
                                            hw[2], hw[11], hw[5:3], 1'b0};
                        end
                        default: begin // C.BEQZ C.BNEZ
                            decode_o.rs1 = creg(hw[9:7]);
                            decode_o.imm = {{12{hw[12]}}, hw[12], hw[6:5], hw[2], hw[11:10],
                                            hw[4:3], 1'b0};
                        end
                    endcase
                end
                C_Q2: begin
                    case (cv.funct3)
                        3'b000: begin // C.SLLI
                            decode_o.rd  = cv.hi5;
                            decode_o.rs1 = cv.hi5;
                            decode_o.imm = {15'd0, hw[12], hw[6:2]};
                        end
                        3'b010, 3'b011: if (cv.hi5 != '0) begin // C.LWSP C.LDSP
                            decode_o.rd  = cv.hi5;
                            decode_o.rs1 = SP_IDX;
                            if (cv.funct3[0]) begin
                                decode_o.imm = {12'd0, hw[4:2], hw[12], hw[6:5], 3'b000};
                            end else begin
                                decode_o.imm = {13'd0, hw[3:2], hw[12], hw[6:4], 2'b00};
                            end
                        end
                        3'b100: begin
                            decode_o.funct7 = {hw[15:12], 3'b000};
                            decode_o.rs2    = cv.lo5;
                            if (!cv.b12) begin
                                if (cv.lo5 != '0) begin // C.MV
                                    decode_o.rd     = cv.hi5;
                                    decode_o.c_flag = 1'b1;
                                end else begin // C.JR
                                    decode_o.rs1 = cv.hi5;
                                end
                            end else if (cv.lo5 == '0 && cv.hi5 != '0) begin // C.JALR
                                decode_o.rd     = RA_IDX;
                                decode_o.rs1    = cv.hi5;
                                decode_o.c_flag = 1'b1;
                            end else begin // C.ADD, or C.EBREAK with all zero
                                decode_o.rd  = cv.hi5;
                                decode_o.rs1 = cv.hi5;
                            end
                        end
                        3'b110, 3'b111: begin // C.SWSP C.SDSP
                            decode_o.rs1 = SP_IDX;
                            decode_o.rs2 = cv.lo5;
                            if (cv.funct3[0]) begin
                                decode_o.imm = {12'd0, hw[9:7], hw[12:10], 3'b000};
                            end else begin
                                decode_o.imm = {13'd0, hw[8:7], hw[12:9], 2'b00};
                            end
                        end
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/rv_base_decoder.sv ====
// Combinational decoder for the 32-bit base instruction formats
module rv_base_decoder import rv_decode_pkg::*; (
    input rv_word_u     instr,
    rv_decode_if.source decode_o
);

    base_view_t w;

    assign w = instr.b;

    always_comb begin
        decode_o.opcode = w.opcode;
        decode_o.rd     = '0;
        decode_o.rs1    = '0;
        decode_o.rs2    = '0;
        decode_o.funct2 = '0; // No funct2 in base formats
        decode_o.funct3 = '0;
        decode_o.funct7 = '0;
        decode_o.imm    = '0;
        decode_o.c_flag = 1'b0;
        case (w.opcode)
            OPC_LUI, OPC_AUIPC: begin // U-type
                decode_o.rd  = w.rd;
                decode_o.imm = {w.funct7[6], w.funct7, w.rs2, w.rs1, w.funct3};
            end
            OPC_JAL: begin // J-type
                decode_o.rd  = w.rd;
                decode_o.imm = {w.funct7[6], w.rs1, w.funct3, w.rs2[0],
                                w.funct7[5:0], w.rs2[4:1], 1'b0};
            end
            OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32: begin // I-type
                decode_o.rd     = w.rd;
                decode_o.rs1    = w.rs1;
                decode_o.funct3 = w.funct3;
                decode_o.imm    = {{9{w.funct7[6]}}, w.funct7, w.rs2};
            end
            OPC_OP, OPC_OP_32: begin // R-type
                decode_o.rd     = w.rd;
                decode_o.rs1    = w.rs1;
                decode_o.rs2    = w.rs2;
                decode_o.funct3 = w.funct3;
                decode_o.funct7 = w.funct7;
            end
            OPC_BRANCH: begin // B-type
                decode_o.rs1    = w.rs1;
                decode_o.rs2    = w.rs2;
                decode_o.funct3 = w.funct3;
                decode_o.imm    = {{8{w.funct7[6]}}, w.funct7[6], w.rd[0],
                                   w.funct7[5:0], w.rd[4:1], 1'b0};
            end
            OPC_STORE: begin // S-type
                decode_o.rs1    = w.rs1;
                decode_o.rs2    = w.rs2;
                decode_o.funct3 = w.funct3;
                decode_o.imm    = {{9{w.funct7[6]}}, w.funct7, w.rd};
            end
            OPC_MISC_MEM: begin // FENCE, pred/succ kept unsigned
                decode_o.rd  = w.rd;
                decode_o.rs1 = w.rs1;
                decode_o.imm = {9'd0, w.funct7, w.rs2};
            end
            OPC_SYSTEM: begin
                decode_o.imm = {9'd0, w.funct7, w.rs2}; // CSR number or funct12
            end
            default: begin
                decode_o.opcode = '0; // Unknown opcode
            end
        endcase
    end

endmodule

// ==== rtl/rv_decode_if.sv ====
// Interface bundling one set of decoded instruction fields
interface rv_decode_if import rv_decode_pkg::*; ();

    opcode_t    opcode;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [1:0] funct2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_t       imm;
    logic       c_flag;  // C.MV or C.JALR

    // Driven by a decoder
    modport source (
        output opcode, rd, rs1, rs2,
        output funct2, funct3, funct7,
        output imm, c_flag
    );

    // Read by the decode stage
    modport sink (
        input opcode, rd, rs1, rs2,
        input funct2, funct3, funct7,
        input imm, c_flag
    );

endinterface

// ==== rtl/rv_decode_pkg.sv ====
// Decode widths, field types, opcode and quadrant codes, instruction word union, length codes
package rv_decode_pkg;

    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 21;
    localparam int OPCODE_W  = 7;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;
    typedef logic [OPCODE_W-1:0]  opcode_t;

    // Major opcodes of the 32-bit base formats
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_JAL       = 7'b1101111;
    localparam opcode_t OPC_JALR      = 7'b1100111;
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_BRANCH    = 7'b1100011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_MISC_MEM  = 7'b0001111;
    localparam opcode_t OPC_SYSTEM    = 7'b1110011;

    // Compressed quadrant codes in bits 1..0
    localparam logic [1:0] C_Q0 = 2'b00;
    localparam logic [1:0] C_Q1 = 2'b01;
    localparam logic [1:0] C_Q2 = 2'b10;

    typedef enum logic [1:0] {
        LEN_NONE = 2'b00, // Longer than 64 bits and not decoded
        LEN_16   = 2'b01,
        LEN_32   = 2'b10,
        LEN_LONG = 2'b11  // 48-bit and 64-bit encoding space
    } ilen_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } base_view_t;

    typedef struct packed {
        logic [15:0] upper;  // Next parcel when the word is 16 bits
        logic [2:0]  funct3;
        logic        b12;
        logic [4:0]  hi5;    // Bits 11..7 hold rd or rs1 in most forms
        logic [4:0]  lo5;    // Bits 6..2 hold rs2 or immediate bits
        logic [1:0]  quad;
    } comp_view_t;

    typedef union packed {
        base_view_t b;
        comp_view_t c;
    } rv_word_u;

    localparam reg_idx_t RA_IDX = 5'd1;
    localparam reg_idx_t SP_IDX = 5'd2;

endpackage
